// File: design/pcore_periph_pkg.sv
// Peripheral subsystem package with data-bus structs, CLINT register map and window constants
`default_nettype none

package pcore_periph_pkg;

    // ----------------------------------------------------------------------
    // Widths and address window
    // ----------------------------------------------------------------------
    localparam int unsigned XLEN             = 32;
    localparam int unsigned CLINT_ADDR_WIDTH = 5;

    // Upper half of the CLINT window, 0x0200_xxxx
    localparam logic [15:0] CLINT_BASE_HI    = 16'h0200;

    // ----------------------------------------------------------------------
    // Data bus
    // ----------------------------------------------------------------------
    // Master request towards a peripheral
    typedef struct packed {
        logic [31:0]     addr;
        logic [XLEN-1:0] w_data;
        logic            w_en;
        logic            cyc;     // live bus cycle
    } type_dbus2peri_s;

    // Peripheral response back to the master
    typedef struct packed {
        logic [XLEN-1:0] r_data;
        logic            ack;     // one cycle wide
    } type_peri2dbus_s;

    // mtime export to the CSR file
    typedef struct packed {
        logic [XLEN-1:0] time_lo;
        logic [XLEN-1:0] time_hi;
    } type_clint2csr_s;

    // ----------------------------------------------------------------------
    // CLINT register offsets
    // ----------------------------------------------------------------------
    typedef enum logic [CLINT_ADDR_WIDTH-1:0] {
        MSIP_R          = 5'h00,
        MTIMECMP_LOW_R  = 5'h08,
        MTIMECMP_HIGH_R = 5'h0C,
        MTIME_LOW_R     = 5'h10,
        MTIME_HIGH_R    = 5'h14
    } clint_reg_e;

endpackage

`default_nettype wire

// File: design/clint_tick_gen.sv
// CLINT prescaler giving a one-cycle mtime tick enable every PRESCALE_DIV clocks
`timescale 1ns/1ps
`default_nettype none

module clint_tick_gen #(
    parameter int unsigned PRESCALE_DIV = 80
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick_o
);

    // Counter just wide enough for 0 .. PRESCALE_DIV-1
    localparam int unsigned CNT_W = (PRESCALE_DIV > 1) ? $clog2(PRESCALE_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PRESCALE_DIV - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             cnt_wrap;

    // Top of the count
    assign cnt_wrap = (cnt_q == CNT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (cnt_wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Enable instead of a derived clock, mtime stays on clk
    assign tick_o = cnt_wrap;

endmodule

`default_nettype wire

// File: design/clint.sv
// Core-local interruptor with msip, mtime and mtimecmp registers on the data bus
`timescale 1ns/1ps
`default_nettype none

module clint (
    input  logic                              clk,
    input  logic                              rst_n,
    input  pcore_periph_pkg::type_dbus2peri_s dbus2clint_i,
    input  logic                              clint_sel_i,
    input  logic                              tick_i,
    output pcore_periph_pkg::type_peri2dbus_s clint2dbus_o,
    output pcore_periph_pkg::type_clint2csr_s clint2csr_o,
    output logic                              clint_timer_irq_o,
    output logic                              clint_soft_irq_o
);

    localparam int unsigned XLEN = pcore_periph_pkg::XLEN;
    localparam int unsigned AW   = pcore_periph_pkg::CLINT_ADDR_WIDTH;

    pcore_periph_pkg::clint_reg_e addr_offset;
    logic [XLEN-1:0]              w_data;
    logic                         r_req;
    logic                         w_req;
    logic                         wr_ok;
    logic [XLEN-1:0]              rd_mux;

    // Write strobes per register
    logic msip_wr;
    logic mtime_lo_wr;
    logic mtime_hi_wr;
    logic mtimecmp_lo_wr;
    logic mtimecmp_hi_wr;

    logic            msip_q;
    logic [63:0]     mtime_q;
    logic [63:0]     mtime_d;
    logic [63:0]     mtimecmp_q;
    logic            timer_irq_q;
    logic            ack_q;
    logic [XLEN-1:0] r_data_q;

    // ----------------------------------------------------------------------
    // Bus request decode
    // ----------------------------------------------------------------------
    assign addr_offset = pcore_periph_pkg::clint_reg_e'(dbus2clint_i.addr[AW-1:0]);
    assign w_data      = dbus2clint_i.w_data;
    assign r_req       = dbus2clint_i.cyc & clint_sel_i & ~dbus2clint_i.w_en;
    assign w_req       = dbus2clint_i.cyc & clint_sel_i & dbus2clint_i.w_en;

    // No second write while the ack is still out
    assign wr_ok = w_req & ~ack_q;

    always_comb begin
        msip_wr        = 1'b0;
        mtime_lo_wr    = 1'b0;
        mtime_hi_wr    = 1'b0;
        mtimecmp_lo_wr = 1'b0;
        mtimecmp_hi_wr = 1'b0;
        if (wr_ok) begin
            case (addr_offset)
                pcore_periph_pkg::MSIP_R:          msip_wr        = 1'b1;
                pcore_periph_pkg::MTIME_LOW_R:     mtime_lo_wr    = 1'b1;
                pcore_periph_pkg::MTIME_HIGH_R:    mtime_hi_wr    = 1'b1;
                pcore_periph_pkg::MTIMECMP_LOW_R:  mtimecmp_lo_wr = 1'b1;
                pcore_periph_pkg::MTIMECMP_HIGH_R: mtimecmp_hi_wr = 1'b1;
                default: ;  // unknown offset, write dropped
            endcase
        end
    end

    // Read mux, unknown offsets give zero
    always_comb begin
        case (addr_offset)
            pcore_periph_pkg::MSIP_R:          rd_mux = {{(XLEN-1){1'b0}}, msip_q};
            pcore_periph_pkg::MTIME_LOW_R:     rd_mux = mtime_q[31:0];
            pcore_periph_pkg::MTIME_HIGH_R:    rd_mux = mtime_q[63:32];
            pcore_periph_pkg::MTIMECMP_LOW_R:  rd_mux = mtimecmp_q[31:0];
            pcore_periph_pkg::MTIMECMP_HIGH_R: rd_mux = mtimecmp_q[63:32];
            default:                           rd_mux = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Registers
    // ----------------------------------------------------------------------
    // msip holds bit 0 only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip_q <= 1'b0;
        end else if (msip_wr) begin
            msip_q <= w_data[0];
        end
    end

    // mtime next value, a bus write wins over the tick
    always_comb begin
        mtime_d = mtime_q;
        if (tick_i) begin
            mtime_d = mtime_q + 64'd1;
        end
        if (mtime_lo_wr) begin
            mtime_d = {mtime_q[63:32], w_data};
        end else if (mtime_hi_wr) begin
            mtime_d = {w_data, mtime_q[31:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_d;
        end
    end

    // Compare register, one half per write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '0;
        end else if (mtimecmp_lo_wr) begin
            mtimecmp_q[31:0] <= w_data;
        end else if (mtimecmp_hi_wr) begin
            mtimecmp_q[63:32] <= w_data;
        end
    end

    // ----------------------------------------------------------------------
    // Interrupts
    // ----------------------------------------------------------------------
    // Registered compare, lags mtime/mtimecmp by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq_q <= 1'b0;
        end else begin
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign clint_timer_irq_o = timer_irq_q;
    assign clint_soft_irq_o  = msip_q;

    // ----------------------------------------------------------------------
    // Bus response
    // ----------------------------------------------------------------------
    // Ack one cycle after the request, never twice in a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= (r_req | w_req) & ~ack_q;
        end
    end

    // Read data lines up with ack, zero otherwise
    always_ff @(posedge clk) begin
        if (r_req & ~ack_q) begin
            r_data_q <= rd_mux;
        end else begin
            r_data_q <= '0;
        end
    end

    assign clint2dbus_o.ack    = ack_q;
    assign clint2dbus_o.r_data = r_data_q;

    // Live timer value for the CSR file
    assign clint2csr_o.time_lo = mtime_q[31:0];
    assign clint2csr_o.time_hi = mtime_q[63:32];

endmodule

`default_nettype wire

// File: design/dbus_periph_decoder.sv
// Data-bus decoder steering cycles to the CLINT and answering unmapped addresses
`timescale 1ns/1ps
`default_nettype none

module dbus_periph_decoder (
    input  logic                              clk,
    input  logic                              rst_n,
    input  pcore_periph_pkg::type_dbus2peri_s dbus2peri_i,
    output pcore_periph_pkg::type_peri2dbus_s peri2dbus_o,
    output logic                              clint_sel_o,
    output pcore_periph_pkg::type_dbus2peri_s dbus2clint_o,
    input  pcore_periph_pkg::type_peri2dbus_s clint2dbus_i
);

    logic                              unmapped;
    logic                              accept;
    logic                              clint_sel_q;
    logic                              def_ack_q;
    pcore_periph_pkg::type_peri2dbus_s clint_rsp;
    pcore_periph_pkg::type_peri2dbus_s def_rsp;

    // ----------------------------------------------------------------------
    // Address window
    // ----------------------------------------------------------------------
    assign clint_sel_o  = dbus2peri_i.cyc &
                          (dbus2peri_i.addr[31:16] == pcore_periph_pkg::CLINT_BASE_HI);
    assign unmapped     = dbus2peri_i.cyc & ~clint_sel_o;
    assign dbus2clint_o = dbus2peri_i;

    // New cycle taken when no ack is out
    assign accept = dbus2peri_i.cyc & ~peri2dbus_o.ack;

    // Select as seen when the cycle was taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clint_sel_q <= 1'b0;
        end else if (accept) begin
            clint_sel_q <= clint_sel_o;
        end
    end

    // Default responder, one-cycle ack with zero data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            def_ack_q <= 1'b0;
        end else begin
            def_ack_q <= unmapped & ~def_ack_q;
        end
    end

    // ----------------------------------------------------------------------
    // Response merge
    // ----------------------------------------------------------------------
    assign clint_rsp      = clint_sel_q ? clint2dbus_i : '0;
    assign def_rsp.r_data = '0;
    assign def_rsp.ack    = def_ack_q;

    // Only one side is ever active
    assign peri2dbus_o = clint_rsp | def_rsp;

endmodule

`default_nettype wire

// File: design/periph_subsys_top.sv
// Peripheral subsystem top with data-bus decoder, CLINT and mtime prescaler
`timescale 1ns/1ps
`default_nettype none

module periph_subsys_top #(
    parameter int unsigned PRESCALE_DIV = 80
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  pcore_periph_pkg::type_dbus2peri_s dbus2peri_i,
    output pcore_periph_pkg::type_peri2dbus_s peri2dbus_o,
    output pcore_periph_pkg::type_clint2csr_s clint2csr_o,
    output logic                              timer_irq_o,
    output logic                              soft_irq_o
);

    // Decoder to CLINT
    pcore_periph_pkg::type_dbus2peri_s dbus2clint;
    pcore_periph_pkg::type_peri2dbus_s clint2dbus;
    logic                              clint_sel;
    logic                              mtime_tick;

    // ----------------------------------------------------------------------
    // Bus decode
    // ----------------------------------------------------------------------
    dbus_periph_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .dbus2peri_i  (dbus2peri_i),
        .peri2dbus_o  (peri2dbus_o),
        .clint_sel_o  (clint_sel),
        .dbus2clint_o (dbus2clint),
        .clint2dbus_i (clint2dbus)
    );

    // mtime enable
    clint_tick_gen #(
        .PRESCALE_DIV (PRESCALE_DIV)
    ) u_tick_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick_o (mtime_tick)
    );

    // ----------------------------------------------------------------------
    // CLINT
    // ----------------------------------------------------------------------
    clint u_clint (
        .clk               (clk),
        .rst_n             (rst_n),
        .dbus2clint_i      (dbus2clint),
        .clint_sel_i       (clint_sel),
        .tick_i            (mtime_tick),
        .clint2dbus_o      (clint2dbus),
        .clint2csr_o       (clint2csr_o),
        .clint_timer_irq_o (timer_irq_o),
        .clint_soft_irq_o  (soft_irq_o)
    );

endmodule

`default_nettype wire

// File: tb/periph_checker.sv
// Response checker comparing bus read data, mtime export and interrupts with expected values
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
    input logic                              clk,
    input pcore_periph_pkg::type_peri2dbus_s rsp_i,
    input pcore_periph_pkg::type_clint2csr_s csr_i,
    input logic                              timer_irq_i,
    input logic                              soft_irq_i
);

    // Running totals read by the testbench top
    int pass_cnt = 0;
    int fail_cnt = 0;

    // ----------------------------------------------------------------------
    // Bookkeeping
    // ----------------------------------------------------------------------
    task automatic flag_error(input int id, input string what);
        fail_cnt++;
        $display("[%0t] test %0d FAIL: %s", $time, id, what);
    endtask

    task automatic mark_pass(input int id, input string op);
        pass_cnt++;
        $display("[%0t] test %0d %s ok", $time, id, op);
    endtask

    // Value inside lo .. lo + span
    function automatic bit in_window(input logic [31:0] value, input logic [31:0] lo,
                                     input logic [31:0] span);
        return (value >= lo) && ((value - lo) <= span);
    endfunction

    // ----------------------------------------------------------------------
    // Bus response sampled in the ack cycle
    // ----------------------------------------------------------------------
    task automatic check_ack(input int id, input string op, input bit is_rd, input bit is_rng,
                             input logic [31:0] lo, input logic [31:0] span,
                             input logic [31:0] hi);
        if (!rsp_i.ack) begin
            flag_error(id, "no ack within 1 cycle of the request");
        end else if (is_rd && !in_window(rsp_i.r_data, lo, span)) begin
            fail_cnt++;
            $display("MISMATCH at %0t: test %0d %s read 0x%08h, expected 0x%08h plus up to %0d",
                     $time, id, op, rsp_i.r_data, lo, span);
        end else if (is_rng && !in_window(csr_i.time_lo, lo, span)) begin
            // CSR export may already carry the tick from this edge
            fail_cnt++;
            $display("MISMATCH at %0t: test %0d time_lo 0x%08h, expected 0x%08h plus up to %0d",
                     $time, id, csr_i.time_lo, lo, span);
        end else if (is_rng && csr_i.time_hi !== hi) begin
            // Upper half of the export holds the last written mtime high word
            fail_cnt++;
            $display("MISMATCH at %0t: test %0d time_hi 0x%08h, expected 0x%08h",
                     $time, id, csr_i.time_hi, hi);
        end else begin
            mark_pass(id, op);
        end
    endtask

    // ----------------------------------------------------------------------
    // Interrupt wait on falling edges
    // ----------------------------------------------------------------------
    task automatic wait_irq(input int id, input string op, input bit use_soft, input bit exp,
                            input int tol);
        int   n;
        logic seen;
        n    = 0;
        seen = use_soft ? soft_irq_i : timer_irq_i;
        while (seen !== exp && n < tol) begin
            @(negedge clk);
            n++;
            seen = use_soft ? soft_irq_i : timer_irq_i;
        end
        if (seen === exp) begin
            mark_pass(id, op);
        end else begin
            flag_error(id, $sformatf("%s interrupt did not reach %0d within %0d cycles",
                                     use_soft ? "software" : "timer", exp, tol));
        end
    endtask

endmodule

`default_nettype wire

// File: tb/periph_subsys_assertions.sv
// Concurrent checks on the data-bus handshake of the peripheral subsystem
`timescale 1ns/1ps
`default_nettype none

module periph_subsys_assertions (
    input logic                              clk,
    input logic                              rst_n,
    input pcore_periph_pkg::type_dbus2peri_s req_i,
    input pcore_periph_pkg::type_peri2dbus_s rsp_i
);

    // One-cycle ack
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_i.ack |=> !rsp_i.ack)
        else $error("ack held high for two cycles");

    // Fresh request answered at the next edge
    ack_follows_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        (req_i.cyc && !rsp_i.ack) |=> rsp_i.ack)
        else $error("request not acknowledged one cycle later");

    // No ack without a request the cycle before
    ack_has_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_i.ack |-> $past(req_i.cyc))
        else $error("ack without a preceding request");

    // Quiet bus while in reset
    ack_reset_low: assert property (@(posedge clk) !rst_n |-> !rsp_i.ack)
        else $error("ack high during reset");

endmodule

`default_nettype wire

// File: tb/tb_periph_subsys.sv
// Testbench for the peripheral subsystem, replaying bus operations from a testdata file
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsys;

    localparam int unsigned PRESCALE_DIV = 4;
    localparam int unsigned CLK_HALF     = 4;
    localparam int unsigned RST_CYCLES   = 8;
    localparam int unsigned CYC_PER_OP   = 200;

    // Full address of MTIME_LOW_R
    localparam logic [31:0] MTIME_LO_ADDR = {pcore_periph_pkg::CLINT_BASE_HI, 11'd0,
                                             pcore_periph_pkg::MTIME_LOW_R};
    // Full address of MTIME_HIGH_R
    localparam logic [31:0] MTIME_HI_ADDR = {pcore_periph_pkg::CLINT_BASE_HI, 11'd0,
                                             pcore_periph_pkg::MTIME_HIGH_R};

    logic                              clk;
    logic                              rst_n;
    pcore_periph_pkg::type_dbus2peri_s bus_req;
    pcore_periph_pkg::type_peri2dbus_s bus_rsp;
    pcore_periph_pkg::type_clint2csr_s csr_time;
    logic                              timer_irq;
    logic                              soft_irq;

    // Parsed testdata records
    int          id_q[$];
    string       op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    int          tol_q[$];
    int          n_ops        = 0;
    int          cyc_cnt      = 0;
    int          mtime_wr_cyc = 0;
    // Last value written to the mtime high word
    logic [31:0] mtime_hi_val = '0;

    // ----------------------------------------------------------------------
    // DUT, checker and bound assertions
    // ----------------------------------------------------------------------
    periph_subsys_top #(
        .PRESCALE_DIV (PRESCALE_DIV)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus2peri_i (bus_req),
        .peri2dbus_o (bus_rsp),
        .clint2csr_o (csr_time),
        .timer_irq_o (timer_irq),
        .soft_irq_o  (soft_irq)
    );

    periph_checker u_checker (
        .clk         (clk),
        .rsp_i       (bus_rsp),
        .csr_i       (csr_time),
        .timer_irq_i (timer_irq),
        .soft_irq_i  (soft_irq)
    );

    bind periph_subsys_top periph_subsys_assertions u_assertions (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (dbus2peri_i),
        .rsp_i (peri2dbus_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Cycle count for the mtime tolerance
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // ----------------------------------------------------------------------
    // Testdata reader skipping comment and blank lines
    // ----------------------------------------------------------------------
    task automatic load_testdata();
        int          fd;
        int          id;
        int          tol;
        string       line;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        fd = $fopen("tb/periph_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/periph_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%d %s %h %h %d", id, op, addr, data, tol) == 5) begin
                        id_q.push_back(id);
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        tol_q.push_back(tol);
                    end
                end
            end
            $fclose(fd);
            n_ops = id_q.size();
        end
    endtask

    // Idle cycle then one bus cycle that returns in its ack cycle
    task automatic bus_cycle(input int idx);
        logic        is_wr;
        logic        is_rng;
        logic [31:0] span;
        is_wr  = (op_q[idx] == "WR");
        is_rng = (op_q[idx] == "RDR");
        // Bus idle for one edge before the next request
        @(negedge clk);
        bus_req.addr   = addr_q[idx];
        bus_req.w_data = is_wr ? data_q[idx] : '0;
        bus_req.w_en   = is_wr;
        bus_req.cyc    = 1'b1;
        @(negedge clk);
        // mtime may have ticked once per PRESCALE_DIV cycles since it was written
        span = is_rng ? 32'((cyc_cnt - mtime_wr_cyc) / PRESCALE_DIV + tol_q[idx]) : '0;
        u_checker.check_ack(id_q[idx], op_q[idx], !is_wr, is_rng, data_q[idx], span,
                            mtime_hi_val);
        if (is_wr && addr_q[idx] == MTIME_LO_ADDR) begin
            mtime_wr_cyc = cyc_cnt;
        end
        if (is_wr && addr_q[idx] == MTIME_HI_ADDR) begin
            mtime_hi_val = data_q[idx];
        end
        // Drop cyc so it is low at the edge after ack
        bus_req = '0;
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int i;
        bus_req = '0;
        rst_n   = 1'b0;
        load_testdata();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (i = 0; i < n_ops; i++) begin
            if (op_q[i] == "TIRQ" || op_q[i] == "SIRQ") begin
                u_checker.wait_irq(id_q[i], op_q[i], op_q[i] == "SIRQ", data_q[i][0], tol_q[i]);
            end else if (op_q[i] == "WR" || op_q[i] == "RD" || op_q[i] == "RDR") begin
                bus_cycle(i);
            end else begin
                u_checker.flag_error(id_q[i], {"unknown operation ", op_q[i]});
            end
        end
        repeat (2) @(negedge clk);
        if (n_ops == 0) begin
            $display("No test records were read from the testdata file");
        end
        $display("Summary: %0d tests, %0d passed, %0d failed",
                 n_ops, u_checker.pass_cnt, u_checker.fail_cnt);
        if (n_ops > 0 && u_checker.fail_cnt == 0 && u_checker.pass_cnt == n_ops) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the record count
    initial begin
        wait (n_ops > 0);
        repeat (RST_CYCLES + n_ops * CYC_PER_OP) @(posedge clk);
        $display("Timeout: run went past %0d cycles", RST_CYCLES + n_ops * CYC_PER_OP);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/periph_testdata.txt
# id op addr data tol : WR writes data, RD expects data, RDR expects data .. data+elapsed/4+tol
# TIRQ/SIRQ wait up to tol cycles for the interrupt to equal data, addr unused
# Reset state
1  SIRQ 00000000 00000000 0
2  RD   02000008 00000000 0
# Write and read back, msip bit 0 only, unmapped and unknown offsets
3  WR   02000008 a5a55a5a 0
4  RD   02000008 a5a55a5a 0
5  WR   0200000c 0badf00d 0
6  RD   0200000c 0badf00d 0
7  WR   02000000 fffffffe 0
8  RD   02000000 00000000 0
9  WR   30000040 deadbeef 0
10 RD   30000040 00000000 0
11 WR   02000018 12345678 0
12 RD   02000018 00000000 0
# mtime write and advance
13 WR   02000014 12345678 0
14 WR   02000010 00001000 0
15 RD   02000014 12345678 0
16 RDR  02000010 00001000 1
# Timer interrupt
17 WR   0200000c ffffffff 0
18 TIRQ 00000000 00000000 1
19 WR   02000010 00002000 0
20 WR   02000008 00002003 0
21 WR   0200000c 12345678 0
22 TIRQ 00000000 00000001 20
23 WR   0200000c ffffffff 0
24 TIRQ 00000000 00000000 1
# Software interrupt
25 WR   02000000 00000003 0
26 SIRQ 00000000 00000001 0
27 RD   02000000 00000001 0
28 WR   02000000 00000000 0
29 SIRQ 00000000 00000000 0

// File: sources.f
design/pcore_periph_pkg.sv
design/clint_tick_gen.sv
design/clint.sv
design/dbus_periph_decoder.sv
design/periph_subsys_top.sv
tb/periph_checker.sv
tb/periph_subsys_assertions.sv
tb/tb_periph_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_periph_subsys \
    -Mdir obj_dir -o Vtb_periph_subsys -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_periph_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
exit 1
